/* logic/cfg_pkg.sv */
package cfg_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  ram_addr_t;
    typedef logic [2:0]  word_idx_t;
    typedef logic [7:0]  rate_t;
    typedef logic [63:0] sync_time_t;

    localparam ram_addr_t ADDR_CTL_FLAG   = 8'h00;
    localparam ram_addr_t ADDR_FPGA_STATE = 8'h01;
    localparam ram_addr_t ADDR_VERSION    = 8'h02;

    // mode, rate intensity, rate phase, steps intensity, steps phase.
    localparam ram_addr_t ADDR_SILENCER_BASE = 8'h40;
    localparam word_idx_t SILENCER_WORDS     = 3'd5;

    localparam ram_addr_t ADDR_SYNC_BASE = 8'h50; // least significant word first.
    localparam word_idx_t SYNC_WORDS     = 3'd4;

    localparam int FLAG_BIT_SILENCER_SET = 0;
    localparam int FLAG_BIT_SYNC_SET     = 1;

    localparam logic [7:0] VERSION_MAJOR = 8'hA2;
    localparam logic [7:0] VERSION_MINOR = 8'h01;

    localparam int FPGA_STATE_BIT_THERMO = 0;

    localparam int READ_LATENCY = 2; // controller port, address register to data.

    localparam logic  SILENCER_MODE_DEFAULT            = 1'b1; // fixed completion steps.
    localparam rate_t SILENCER_RATE_DEFAULT            = 8'd1;
    localparam rate_t SILENCER_STEPS_INTENSITY_DEFAULT = 8'd10;
    localparam rate_t SILENCER_STEPS_PHASE_DEFAULT     = 8'd40;

    localparam sync_time_t SYNC_TIME_DEFAULT = 64'd0;

endpackage

/* logic/cnt_ram.sv */
module cnt_ram import cfg_pkg::*; (
    input  logic      CLK,
    input  logic      rst,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  ram_addr_t paddr,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    input  logic      ctl_we,
    input  ram_addr_t ctl_addr,
    input  word_t     ctl_din,
    output word_t     ctl_dout
);

    word_t     mem [2**$bits(ram_addr_t)];
    ram_addr_t host_addr_q;
    logic      rd_second;
    logic      host_we;
    word_t     ctl_rd_q;

    assign host_we = psel && penable && pwrite;
    assign pready  = psel && penable && (pwrite || rd_second); // reads take two access cycles.

    always_ff @(posedge CLK) begin
        if (rst) begin
            rd_second <= 1'b0;
        end else begin
            rd_second <= psel && penable && !pwrite && !rd_second;
        end
    end

    always_ff @(posedge CLK) begin
        if (host_we) begin
            mem[paddr] <= pwdata;
        end
        if (ctl_we) begin
            mem[ctl_addr] <= ctl_din; // the controller wins a same-word collision.
        end
    end

    always_ff @(posedge CLK) begin
        if (psel) begin
            host_addr_q <= paddr;
            prdata      <= mem[host_addr_q];
        end
    end

    always_ff @(posedge CLK) begin
        ctl_rd_q <= mem[ctl_addr];
        ctl_dout <= ctl_rd_q;
    end

    // the host must hold address and direction for the whole transfer.
    assert property (@(posedge CLK) disable iff (rst)
        psel && penable |-> $stable(paddr) && $stable(pwrite))
        else $error("APB address or direction changed during access phase.");

endmodule

/* logic/load_counter.sv */
module load_counter import cfg_pkg::*; (
    input  logic      CLK,
    input  logic      rst,
    input  logic      start,
    input  word_idx_t word_count,
    output logic      req_valid,
    output word_idx_t req_index,
    output logic      cap_valid,
    output word_idx_t cap_index,
    output logic      done
);

    word_idx_t             last_index;
    logic [READ_LATENCY:0] valid_sr; // extra stage covers the sequencer's address register.
    word_idx_t             idx_sr [READ_LATENCY+1];

    assign cap_valid = valid_sr[READ_LATENCY];
    assign cap_index = idx_sr[READ_LATENCY];

    always_ff @(posedge CLK) begin
        if (rst) begin
            req_valid <= 1'b0;
            valid_sr  <= '0;
            done      <= 1'b0;
        end else begin
            if (start) begin
                req_valid <= 1'b1;
            end else if (req_valid && req_index == last_index) begin
                req_valid <= 1'b0;
            end
            valid_sr <= {valid_sr[READ_LATENCY-1:0], req_valid};
            done     <= cap_valid && !valid_sr[READ_LATENCY-1]; // falling edge of the stream.
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            req_index  <= '0;
            last_index <= word_count - 3'd1;
        end else if (req_valid) begin
            req_index <= req_index + 3'd1;
        end
        idx_sr[0] <= req_index;
        for (int i = 1; i <= READ_LATENCY; i++) begin
            idx_sr[i] <= idx_sr[i-1];
        end
    end

    assert property (@(posedge CLK) disable iff (rst) start |-> !(req_valid || |valid_sr))
        else $error("load started while a previous load is still running.");

endmodule

/* logic/cfg_sequencer.sv */
module cfg_sequencer import cfg_pkg::*; (
    input  logic      CLK,
    input  logic      rst,
    input  logic      thermo,
    output logic      ctl_we,
    output ram_addr_t ctl_addr,
    output word_t     ctl_din,
    input  word_t     ctl_dout,
    output logic      start,
    output word_idx_t word_count,
    input  logic      req_valid,
    input  word_idx_t req_index,
    input  logic      cap_valid,
    input  logic      done,
    output logic      silencer_load,
    output logic      sync_load,
    output logic      silencer_update,
    output logic      sync_update
);

    typedef enum logic [2:0] {
        ST_VER_WR,
        ST_FLAG_REQ,
        ST_FLAG_WAIT,
        ST_FLAG_DECIDE,
        ST_LOAD,
        ST_WB_FLAGS,
        ST_WR_STATE,
        ST_UPDATE
    } state_t;

    state_t    state;
    word_t     flags_q;  // local copy of the control flags.
    logic      grp_sync; // high while the sync group is being handled.
    logic [1:0] wait_cnt;
    word_t     state_word;
    ram_addr_t grp_base;

    always_comb begin
        state_word = '0;
        state_word[FPGA_STATE_BIT_THERMO] = thermo;
    end

    assign grp_base      = grp_sync ? ADDR_SYNC_BASE : ADDR_SILENCER_BASE;
    assign silencer_load = cap_valid && (state == ST_LOAD) && !grp_sync;
    assign sync_load     = cap_valid && (state == ST_LOAD) && grp_sync;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state           <= ST_VER_WR;
            ctl_we          <= 1'b0;
            start           <= 1'b0;
            silencer_update <= 1'b0;
            sync_update     <= 1'b0;
            wait_cnt        <= '0;
        end else begin
            ctl_we          <= 1'b0;
            start           <= 1'b0;
            silencer_update <= 1'b0;
            sync_update     <= 1'b0;
            case (state)
                ST_VER_WR: begin
                    ctl_we   <= 1'b1;
                    ctl_addr <= ADDR_VERSION;
                    ctl_din  <= {VERSION_MAJOR, VERSION_MINOR};
                    state    <= ST_FLAG_REQ;
                end
                ST_FLAG_REQ: begin
                    ctl_addr <= ADDR_CTL_FLAG;
                    wait_cnt <= '0;
                    state    <= ST_FLAG_WAIT;
                end
                ST_FLAG_WAIT: begin
                    if (wait_cnt == '0) begin // status write while the flag read is in flight.
                        ctl_we   <= 1'b1;
                        ctl_addr <= ADDR_FPGA_STATE;
                        ctl_din  <= state_word;
                    end
                    if (wait_cnt == 2'(READ_LATENCY - 1)) begin
                        state <= ST_FLAG_DECIDE;
                    end else begin
                        wait_cnt <= wait_cnt + 2'd1;
                    end
                end
                ST_FLAG_DECIDE: begin
                    flags_q <= ctl_dout;
                    if (ctl_dout[FLAG_BIT_SILENCER_SET]) begin
                        flags_q[FLAG_BIT_SILENCER_SET] <= 1'b0;
                        grp_sync   <= 1'b0;
                        word_count <= SILENCER_WORDS;
                        start      <= 1'b1;
                        state      <= ST_LOAD;
                    end else if (ctl_dout[FLAG_BIT_SYNC_SET]) begin
                        flags_q[FLAG_BIT_SYNC_SET] <= 1'b0;
                        grp_sync   <= 1'b1;
                        word_count <= SYNC_WORDS;
                        start      <= 1'b1;
                        state      <= ST_LOAD;
                    end else begin
                        state <= ST_FLAG_REQ;
                    end
                end
                ST_LOAD: begin
                    if (req_valid) begin
                        ctl_addr <= grp_base + ram_addr_t'(req_index);
                    end
                    if (done) begin
                        state <= ST_WB_FLAGS;
                    end
                end
                ST_WB_FLAGS: begin
                    ctl_we   <= 1'b1;
                    ctl_addr <= ADDR_CTL_FLAG;
                    ctl_din  <= flags_q;
                    state    <= ST_WR_STATE;
                end
                ST_WR_STATE: begin
                    ctl_we          <= 1'b1;
                    ctl_addr        <= ADDR_FPGA_STATE;
                    ctl_din         <= state_word;
                    silencer_update <= !grp_sync; // flag write-back lands on this edge.
                    sync_update     <= grp_sync;
                    state           <= ST_UPDATE;
                end
                ST_UPDATE: begin
                    state <= ST_FLAG_REQ;
                end
                default: begin
                    state <= ST_FLAG_REQ;
                end
            endcase
        end
    end

    assert property (@(posedge CLK) disable iff (rst)
        (silencer_update || sync_update) |->
            !(silencer_update && sync_update) ##1 !(silencer_update || sync_update))
        else $error("update pulses overlap or last longer than one cycle.");

endmodule

/* logic/silencer_settings.sv */
module silencer_settings import cfg_pkg::*; (
    input  logic      CLK,
    input  logic      rst,
    input  logic      load,
    input  word_idx_t index,
    input  word_t     data,
    output logic      silencer_mode,
    output rate_t     silencer_update_rate_intensity,
    output rate_t     silencer_update_rate_phase,
    output rate_t     silencer_completion_steps_intensity,
    output rate_t     silencer_completion_steps_phase
);

    always_ff @(posedge CLK) begin
        if (rst) begin
            silencer_mode                       <= SILENCER_MODE_DEFAULT;
            silencer_update_rate_intensity      <= SILENCER_RATE_DEFAULT;
            silencer_update_rate_phase          <= SILENCER_RATE_DEFAULT;
            silencer_completion_steps_intensity <= SILENCER_STEPS_INTENSITY_DEFAULT;
            silencer_completion_steps_phase     <= SILENCER_STEPS_PHASE_DEFAULT;
        end else if (load) begin
            case (index)
                3'd0: begin
                    silencer_mode <= data[0];
                end
                3'd1: begin
                    silencer_update_rate_intensity <= data[7:0];
                end
                3'd2: begin
                    silencer_update_rate_phase <= data[7:0];
                end
                3'd3: begin
                    silencer_completion_steps_intensity <= data[7:0];
                end
                3'd4: begin
                    silencer_completion_steps_phase <= data[7:0];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* logic/sync_settings.sv */
module sync_settings import cfg_pkg::*; (
    input  logic       CLK,
    input  logic       rst,
    input  logic       load,
    input  word_idx_t  index,
    input  word_t      data,
    output sync_time_t ecat_sync_time
);

    always_ff @(posedge CLK) begin
        if (rst) begin
            ecat_sync_time <= SYNC_TIME_DEFAULT;
        end else if (load && index < SYNC_WORDS) begin
            ecat_sync_time[16*index[1:0] +: 16] <= data; // word 0 is the low slice.
        end
    end

endmodule

/* logic/cfg_controller_top.sv */
module cfg_controller_top import cfg_pkg::*; (
    input  logic       CLK,
    input  logic       rst,
    input  logic       thermo,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  ram_addr_t  paddr,
    input  word_t      pwdata,
    output word_t      prdata,
    output logic       pready,
    output logic       silencer_mode,
    output rate_t      silencer_update_rate_intensity,
    output rate_t      silencer_update_rate_phase,
    output rate_t      silencer_completion_steps_intensity,
    output rate_t      silencer_completion_steps_phase,
    output logic       silencer_update,
    output sync_time_t ecat_sync_time,
    output logic       sync_update
);

    logic      ctl_we;
    ram_addr_t ctl_addr;
    word_t     ctl_din;
    word_t     ctl_dout;
    logic      start;
    word_idx_t word_count;
    logic      req_valid;
    word_idx_t req_index;
    logic      cap_valid;
    word_idx_t cap_index;
    logic      done;
    logic      silencer_load;
    logic      sync_load;

    cnt_ram ram_i (
        .CLK      (CLK),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .ctl_we   (ctl_we),
        .ctl_addr (ctl_addr),
        .ctl_din  (ctl_din),
        .ctl_dout (ctl_dout)
    );

    cfg_sequencer seq_i (
        .CLK             (CLK),
        .rst             (rst),
        .thermo          (thermo),
        .ctl_we          (ctl_we),
        .ctl_addr        (ctl_addr),
        .ctl_din         (ctl_din),
        .ctl_dout        (ctl_dout),
        .start           (start),
        .word_count      (word_count),
        .req_valid       (req_valid),
        .req_index       (req_index),
        .cap_valid       (cap_valid),
        .done            (done),
        .silencer_load   (silencer_load),
        .sync_load       (sync_load),
        .silencer_update (silencer_update),
        .sync_update     (sync_update)
    );

    load_counter cnt_i (
        .CLK        (CLK),
        .rst        (rst),
        .start      (start),
        .word_count (word_count),
        .req_valid  (req_valid),
        .req_index  (req_index),
        .cap_valid  (cap_valid),
        .cap_index  (cap_index),
        .done       (done)
    );

    silencer_settings sil_i (
        .CLK                                 (CLK),
        .rst                                 (rst),
        .load                                (silencer_load),
        .index                               (cap_index),
        .data                                (ctl_dout),
        .silencer_mode                       (silencer_mode),
        .silencer_update_rate_intensity      (silencer_update_rate_intensity),
        .silencer_update_rate_phase          (silencer_update_rate_phase),
        .silencer_completion_steps_intensity (silencer_completion_steps_intensity),
        .silencer_completion_steps_phase     (silencer_completion_steps_phase)
    );

    sync_settings sync_i (
        .CLK            (CLK),
        .rst            (rst),
        .load           (sync_load),
        .index          (cap_index),
        .data           (ctl_dout),
        .ecat_sync_time (ecat_sync_time)
    );

endmodule

/* testbench/tb_cfg_controller.sv */
module tb_cfg_controller import cfg_pkg::*; ();

    localparam int APB_TIMEOUT    = 8;
    localparam int UPDATE_TIMEOUT = 300;
    localparam int MAX_GAP        = 5;

    logic       CLK;
    logic       rst;
    logic       thermo;
    logic       psel;
    logic       penable;
    logic       pwrite;
    ram_addr_t  paddr;
    word_t      pwdata;
    word_t      prdata;
    logic       pready;
    logic       silencer_mode;
    rate_t      silencer_update_rate_intensity;
    rate_t      silencer_update_rate_phase;
    rate_t      silencer_completion_steps_intensity;
    rate_t      silencer_completion_steps_phase;
    logic       silencer_update;
    sync_time_t ecat_sync_time;
    logic       sync_update;

    int mismatches;
    int timeouts;
    int other_errors;
    int silencer_pulses;
    int sync_pulses;

    cfg_controller_top dut_i (
        .CLK                                 (CLK),
        .rst                                 (rst),
        .thermo                              (thermo),
        .psel                                (psel),
        .penable                             (penable),
        .pwrite                              (pwrite),
        .paddr                               (paddr),
        .pwdata                              (pwdata),
        .prdata                              (prdata),
        .pready                              (pready),
        .silencer_mode                       (silencer_mode),
        .silencer_update_rate_intensity      (silencer_update_rate_intensity),
        .silencer_update_rate_phase          (silencer_update_rate_phase),
        .silencer_completion_steps_intensity (silencer_completion_steps_intensity),
        .silencer_completion_steps_phase     (silencer_completion_steps_phase),
        .silencer_update                     (silencer_update),
        .ecat_sync_time                      (ecat_sync_time),
        .sync_update                         (sync_update)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // pulse counters move one edge after the pulse, so they are read at the falling edge.
    always @(posedge CLK) begin
        if (rst) begin
            silencer_pulses <= 0;
            sync_pulses     <= 0;
        end else begin
            if (silencer_update) begin
                silencer_pulses <= silencer_pulses + 1;
            end
            if (sync_update) begin
                sync_pulses <= sync_pulses + 1;
            end
        end
    end

    function automatic int pulse_count(input string name);
        if (name == "silencer") begin
            return silencer_pulses;
        end else if (name == "sync") begin
            return sync_pulses;
        end
        return -1;
    endfunction

    task automatic apb_transfer(input logic wr, input ram_addr_t addr, input word_t wdata,
                                output word_t rdata, output logic ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        rdata  = '0;
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge CLK);
        penable <= 1'b1;
        while (!ok && cycles < APB_TIMEOUT) begin
            @(negedge CLK);
            if (pready) begin
                ok    = 1'b1;
                rdata = prdata; // read data is valid while pready is high.
            end
            cycles++;
        end
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
        if (!ok) begin
            $display("The APB transfer to address %h never saw pready.", addr);
            timeouts++;
        end
    endtask

    task automatic wait_update(input string test, input string name, input int target);
        int cycles;
        cycles = 0;
        if (pulse_count(name) < 0) begin
            $display("Test %0s waits for an unknown update %0s.", test, name);
            other_errors++;
            return;
        end
        @(negedge CLK);
        while (pulse_count(name) < target && cycles < UPDATE_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (pulse_count(name) < target) begin
            $display("Test %0s timed out waiting for %0s update pulse %0d.", test, name, target);
            timeouts++;
        end
    endtask

    task automatic check_pulses(input string test, input string name, input int expected);
        int count;
        @(negedge CLK);
        count = pulse_count(name);
        if (count < 0) begin
            $display("Test %0s counts pulses of an unknown update %0s.", test, name);
            other_errors++;
        end else if (count != expected) begin
            $display("ERROR %0s %0s pulses: expected %0d, actual %0d", test, name, expected, count);
            mismatches++;
        end
    endtask

    task automatic check_output(input string test, input string name,
                                input logic [63:0] expected);
        logic [63:0] actual;
        logic        known;
        @(negedge CLK);
        known = 1'b1;
        case (name)
            "mode":        actual = 64'(silencer_mode);
            "rate_int":    actual = 64'(silencer_update_rate_intensity);
            "rate_phase":  actual = 64'(silencer_update_rate_phase);
            "steps_int":   actual = 64'(silencer_completion_steps_intensity);
            "steps_phase": actual = 64'(silencer_completion_steps_phase);
            "sync_time":   actual = ecat_sync_time;
            default: begin
                known  = 1'b0;
                actual = '0;
            end
        endcase
        if (!known) begin
            $display("Test %0s checks an unknown output %0s.", test, name);
            other_errors++;
        end else if (actual !== expected) begin
            $display("ERROR %0s %0s: expected %0h, actual %0h", test, name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic run_vectors();
        int          fd;
        int          n;
        string       line;
        string       test;
        string       op;
        string       f1;
        string       f2;
        logic [63:0] a1;
        logic [63:0] a2;
        word_t       rdata;
        logic        ok;
        fd = $fopen("testbench/cfg_vectors.txt", "r");
        if (fd == 0) begin
            $display("The vector file testbench/cfg_vectors.txt could not be opened.");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                f1 = "";
                f2 = "";
                a1 = '0;
                a2 = '0;
                n = $sscanf(line, "%s %s %s %s", test, op, f1, f2);
                n = $sscanf(f1, "%h", a1); // names fail this conversion and stay unused.
                n = $sscanf(f2, "%h", a2);
                case (op)
                    "W": begin
                        repeat ($urandom_range(MAX_GAP)) @(posedge CLK);
                        apb_transfer(1'b1, ram_addr_t'(a1), word_t'(a2), rdata, ok);
                    end
                    "R": begin
                        repeat ($urandom_range(MAX_GAP)) @(posedge CLK);
                        apb_transfer(1'b0, ram_addr_t'(a1), '0, rdata, ok);
                        if (ok && rdata !== word_t'(a2)) begin
                            $display("ERROR %0s read %h: expected %h, actual %h",
                                     test, a1[7:0], a2[15:0], rdata);
                            mismatches++;
                        end
                    end
                    "T": begin
                        repeat ($urandom_range(MAX_GAP)) @(posedge CLK);
                        thermo <= a1[0];
                    end
                    "I": begin
                        repeat (int'(a1)) @(posedge CLK);
                    end
                    "U": wait_update(test, f1, int'(a2));
                    "P": check_pulses(test, f1, int'(a2));
                    "C": check_output(test, f1, a2);
                    default: begin
                        $display("The vector line '%0s' has an unknown operation.", line);
                        other_errors++;
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int seed;
        seed         = $urandom(32'hb484);
        mismatches   = 0;
        timeouts     = 0;
        other_errors = 0;
        rst          = 1'b1;
        thermo       = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        repeat (16) @(posedge CLK);
        rst <= 1'b0;
        run_vectors();
        $display("Run finished with %0d mismatches, %0d timeouts and %0d other errors.",
                 mismatches, timeouts, other_errors);
        if (mismatches + timeouts + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
logic/cfg_pkg.sv
logic/cnt_ram.sv
logic/load_counter.sv
logic/cfg_sequencer.sv
logic/silencer_settings.sv
logic/sync_settings.sv
logic/cfg_controller_top.sv
testbench/tb_cfg_controller.sv

/* Bender.yml */
package:
  name: cfg_controller

sources:
  - logic/cfg_pkg.sv
  - logic/cnt_ram.sv
  - logic/load_counter.sv
  - logic/cfg_sequencer.sv
  - logic/silencer_settings.sv
  - logic/sync_settings.sv
  - logic/cfg_controller_top.sv
  - target: test
    files:
      - testbench/tb_cfg_controller.sv

/* testbench/cfg_vectors.txt */
# columns: test op arg1 arg2, all numbers in hex.
# W addr data | R addr expect | T level | I cycles | U update count | P update count | C output expect
reset    C mode        1
reset    C rate_int    1
reset    C rate_phase  1
reset    C steps_int   0a
reset    C steps_phase 28
reset    C sync_time   0
reset    I 14
reset    P silencer    0
reset    P sync        0
version  R 02 a201
scratch  W 10 5a3c
scratch  R 10 5a3c
silencer W 40 0000
silencer W 41 1234
silencer W 42 ff07
silencer W 43 0080
silencer W 44 00c8
silencer W 00 0001
silencer U silencer    1
silencer C mode        0
silencer C rate_int    34
silencer C rate_phase  07
silencer C steps_int   80
silencer C steps_phase c8
silencer R 00 0000
silencer I 14
silencer P silencer    1
sync     W 50 0123
sync     W 51 4567
sync     W 52 89ab
sync     W 53 cdef
sync     W 00 0002
sync     U sync        1
sync     C sync_time   cdef89ab45670123
sync     C mode        0
sync     C rate_int    34
sync     R 00 0000
both     W 41 0055
both     W 50 beef
both     W 00 0003
both     U silencer    2
both     P sync        1
both     U sync        2
both     C rate_int    55
both     C sync_time   cdef89ab4567beef
both     P silencer    2
both     R 00 0000
thermo   T 1
thermo   I 14
thermo   R 01 0001
thermo   T 0
thermo   I 14
thermo   R 01 0000
